//--- verilog/fetchPkg.sv
package fetchPkg;

    // ==============================
    // Instruction word views
    // ==============================

    // One 32-bit word, read as R-type for the function field
    // or as J-type for the jump index
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rType;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] index;
        } jType;
    } instrWord_u;

    // ==============================
    // Opcodes and function codes
    // ==============================

    // SPECIAL group, decoded further by funct
    localparam logic [5:0] opSpecial = 6'd0;

    // Absolute jumps inside the current 256 MB region
    localparam logic [5:0] opJ = 6'd2;
    localparam logic [5:0] opJal = 6'd3;

    // Traps under SPECIAL
    localparam logic [5:0] functSyscall = 6'd12;
    localparam logic [5:0] functBreak = 6'd13;

    // ==============================
    // Fetch defaults
    // ==============================

    // Boot ROM entry of the classic MIPS map (kseg1)
    localparam logic [31:0] defaultResetVector = 32'hBFC0_0000;

endpackage

//--- verilog/instructionFetch.sv
module instructionFetch #(
    parameter logic [31:0] resetVector = fetchPkg::defaultResetVector
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    input  logic        redirect,
    input  logic [31:0] redirectAddr,
    input  logic        respValid,
    input  logic [31:0] respWord,
    input  logic        isJump,
    input  logic [31:0] jumpTarget,
    input  logic        isTrap,
    output logic        fetchReq,
    output logic [31:0] fetchAddr,
    output logic [31:0] pc,
    output logic        instrValid,
    output logic [31:0] instr,
    output logic        exception,
    output logic        halted
);

    // ==============================
    // State
    // ==============================

    // A fetch from fetchAddr is wanted
    logic        armed;
    // Read issued, reply not yet back
    logic        busy;
    // Reply of the open read belongs to an abandoned path
    logic        discard;

    // Delivered word kept while the consumer stalls
    logic        heldValid;
    logic [31:0] heldInstr;

    logic        accept;
    logic        trapHit;
    logic [31:0] nextAddr;
    logic        nextMisaligned;

    // ==============================
    // Delivery
    // ==============================

    assign fetchReq = armed && !busy;

    // A live word counts only if it is on the current path
    assign accept = respValid && !discard && !redirect;

    // Jump wins over trap when both decode
    assign trapHit = isTrap && !isJump;

    assign instrValid = accept || heldValid;
    assign instr = heldValid ? heldInstr : respWord;

    // Next fetch address: redirect, then jump, then sequential
    always_comb begin
        if (redirect) begin
            nextAddr = redirectAddr;
        end else if (isJump) begin
            nextAddr = jumpTarget;
        end else begin
            nextAddr = pc + 32'd4;
        end
    end

    assign nextMisaligned = nextAddr[1:0] != 2'b00;

    // ==============================
    // Control
    // ==============================

    always_ff @(posedge clk) begin
        if (reset) begin
            fetchAddr <= resetVector;
            armed <= resetVector[1:0] == 2'b00;
            busy <= 1'b0;
            discard <= 1'b0;
            heldValid <= 1'b0;
            exception <= resetVector[1:0] != 2'b00;
            halted <= 1'b0;
        end else begin
            // Bus bookkeeping, a request and a reply never share a cycle
            if (fetchReq) begin
                armed <= 1'b0;
                busy <= 1'b1;
            end else if (respValid) begin
                busy <= 1'b0;
                discard <= 1'b0;
            end

            if (redirect) begin
                fetchAddr <= nextAddr;
                armed <= !nextMisaligned;
                exception <= nextMisaligned;
                halted <= 1'b0;
                heldValid <= 1'b0;
                // Read still open or just issued returns a stale word
                if ((busy && !respValid) || fetchReq) begin
                    discard <= 1'b1;
                end
            end else if (accept) begin
                fetchAddr <= nextAddr;
                exception <= nextMisaligned;
                halted <= trapHit;
                heldValid <= stall;
                armed <= !stall && !trapHit && !nextMisaligned;
            end else if (heldValid && !stall) begin
                // Consumer took the held word
                heldValid <= 1'b0;
                armed <= !halted && !exception;
            end
        end
    end

    // pc follows the issued request and stays put until the next one,
    // so it also names the delivered instruction while it is held
    always_ff @(posedge clk) begin
        if (fetchReq) begin
            pc <= fetchAddr;
        end
        if (accept) begin
            heldInstr <= respWord;
        end
    end

endmodule

//--- verilog/fetchBusMaster.sv
module fetchBusMaster (
    input  logic        clk,
    input  logic        reset,
    input  logic        fetchReq,
    input  logic [31:0] fetchAddr,
    input  logic [31:0] wbDatIn,
    input  logic        wbAck,
    output logic        wbCyc,
    output logic        wbStb,
    output logic        wbWe,
    output logic [3:0]  wbSel,
    output logic [31:0] wbAdr,
    output logic        respValid,
    output logic [31:0] respWord
);

    // ==============================
    // Read cycle FSM
    // ==============================

    localparam logic idleState = 1'b0;
    localparam logic busyState = 1'b1;

    logic state;
    logic startRead;
    logic endRead;

    assign startRead = (state == idleState) && fetchReq;
    assign endRead = (state == busyState) && wbAck;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idleState;
            respValid <= 1'b0;
        end else begin
            // Reply strobe lasts one cycle
            respValid <= 1'b0;
            case (state)
                idleState: begin
                    if (fetchReq) begin
                        state <= busyState;
                    end
                end
                busyState: begin
                    if (wbAck) begin
                        state <= idleState;
                        respValid <= 1'b1;
                    end
                end
                default: begin
                    state <= idleState;
                end
            endcase
        end
    end

    // Address held for the whole cycle, data caught on ack
    always_ff @(posedge clk) begin
        if (startRead) begin
            wbAdr <= fetchAddr;
        end
        if (endRead) begin
            respWord <= wbDatIn;
        end
    end

    // ==============================
    // Wishbone outputs
    // ==============================

    // cyc and stb rise and fall together, dropping the cycle after ack
    assign wbCyc = state == busyState;
    assign wbStb = state == busyState;

    // Fetch only reads whole words
    assign wbWe = 1'b0;
    assign wbSel = 4'b1111;

endmodule

//--- verilog/instructionPredecode.sv
module instructionPredecode (
    input  logic        respValid,
    input  logic [31:0] respWord,
    input  logic [31:0] pc,
    output logic        isJump,
    output logic [31:0] jumpTarget,
    output logic        isTrap
);

    import fetchPkg::*;

    instrWord_u  word;
    logic [31:0] pcPlus4;
    logic        jumpOp;
    logic        trapOp;

    assign word = respWord;

    // ==============================
    // Opcode classes
    // ==============================

    // Opcode field sits at the same place in both views
    always_comb begin
        jumpOp = 1'b0;
        trapOp = 1'b0;
        case (word.jType.opcode)
            opJ, opJal: begin
                jumpOp = 1'b1;
            end
            opSpecial: begin
                // Only SYSCALL and BREAK matter here, the rest is ALU work
                case (word.rType.funct)
                    functSyscall, functBreak: begin
                        trapOp = 1'b1;
                    end
                    default: begin
                        trapOp = 1'b0;
                    end
                endcase
            end
            default: begin
                jumpOp = 1'b0;
            end
        endcase
    end

    // ==============================
    // Jump target
    // ==============================

    // Region bits come from the delay-slot address, not the jump itself
    assign pcPlus4 = pc + 32'd4;
    assign jumpTarget = {pcPlus4[31:28], word.jType.index, 2'b00};

    // Flags mean nothing outside the reply cycle
    assign isJump = respValid && jumpOp;
    assign isTrap = respValid && trapOp;

endmodule

//--- verilog/fetchTop.sv
module fetchTop #(
    parameter logic [31:0] resetVector = fetchPkg::defaultResetVector
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    input  logic        redirect,
    input  logic [31:0] redirectAddr,
    input  logic [31:0] wbDatIn,
    input  logic        wbAck,
    output logic        instrValid,
    output logic [31:0] instr,
    output logic [31:0] instrPc,
    output logic        exception,
    output logic        halted,
    output logic        wbCyc,
    output logic        wbStb,
    output logic        wbWe,
    output logic [3:0]  wbSel,
    output logic [31:0] wbAdr
);

    // Request path
    logic        fetchReq;
    logic [31:0] fetchAddr;

    // Reply path
    logic        respValid;
    logic [31:0] respWord;

    // Pre-decode results
    logic        isJump;
    logic [31:0] jumpTarget;
    logic        isTrap;

    // ==============================
    // Fetch sequencing
    // ==============================

    instructionFetch #(
        .resetVector (resetVector)
    ) u_instructionFetch (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .redirect     (redirect),
        .redirectAddr (redirectAddr),
        .respValid    (respValid),
        .respWord     (respWord),
        .isJump       (isJump),
        .jumpTarget   (jumpTarget),
        .isTrap       (isTrap),
        .fetchReq     (fetchReq),
        .fetchAddr    (fetchAddr),
        .pc           (instrPc),
        .instrValid   (instrValid),
        .instr        (instr),
        .exception    (exception),
        .halted       (halted)
    );

    // ==============================
    // Wishbone side
    // ==============================

    fetchBusMaster u_fetchBusMaster (
        .clk       (clk),
        .reset     (reset),
        .fetchReq  (fetchReq),
        .fetchAddr (fetchAddr),
        .wbDatIn   (wbDatIn),
        .wbAck     (wbAck),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbSel     (wbSel),
        .wbAdr     (wbAdr),
        .respValid (respValid),
        .respWord  (respWord)
    );

    // Sees the reply word against the pc it was fetched from
    instructionPredecode u_instructionPredecode (
        .respValid  (respValid),
        .respWord   (respWord),
        .pc         (instrPc),
        .isJump     (isJump),
        .jumpTarget (jumpTarget),
        .isTrap     (isTrap)
    );

endmodule

//--- verif/wishboneRomModel.sv
module wishboneRomModel #(
    parameter integer waitSeed = 32'h51f9_0160
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        wbCyc,
    input  logic        wbStb,
    input  logic [31:0] wbAdr,
    output logic [31:0] wbDatOut,
    output logic        wbAck
);

    timeunit 1ns;
    timeprecision 100ps;

    // Program words, loaded by the testbench before reset ends
    logic [31:0] mem [0:1023];

    integer      seed = waitSeed;
    logic [31:0] roll;
    logic        active;
    logic [1:0]  waitLeft;
    logic [1:0]  pending;

    // ==============================
    // Read response with wait states
    // ==============================

    always @(posedge clk) begin
        if (reset) begin
            wbAck <= 1'b0;
            active <= 1'b0;
        end else if (wbAck) begin
            // Master drops cyc and stb right after ack
            wbAck <= 1'b0;
            active <= 1'b0;
        end else if (wbCyc && wbStb) begin
            // Wait count drawn once per bus cycle, 0 to 3
            if (!active) begin
                roll = $random(seed);
                pending = roll[1:0];
            end else begin
                pending = waitLeft;
            end
            active <= 1'b1;
            if (pending == 2'd0) begin
                wbAck <= 1'b1;
                wbDatOut <= mem[wbAdr[11:2]];
            end else begin
                waitLeft <= pending - 2'd1;
            end
        end
    end

endmodule

//--- verif/fetchTb.sv
module fetchTb;

    timeunit 1ns;
    timeprecision 100ps;

    import fetchPkg::*;

    // ==============================
    // Run parameters
    // ==============================

    localparam logic [31:0] resetVector = 32'h0000_0400;
    localparam int clkPeriod = 40;
    localparam int numInstr = 2000;
    // Stalls and stopped fetch stretch a fetch well past its bus time
    localparam int maxFetchCycles = 40;
    localparam int timeoutNs = numInstr * maxFetchCycles * clkPeriod;
    localparam integer seedInit = 32'h51f9_0160;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        stall = 1'b0;
    logic        redirect = 1'b0;
    logic [31:0] redirectAddr = 32'd0;
    logic        instrValid;
    logic [31:0] instr;
    logic [31:0] instrPc;
    logic        exception;
    logic        halted;
    logic        wbCyc;
    logic        wbStb;
    logic        wbWe;
    logic [3:0]  wbSel;
    logic [31:0] wbAdr;
    logic [31:0] wbDatIn;
    logic        wbAck;

    // Program image and reference state
    logic [31:0] romImage [0:1023];
    integer      seed;
    int          i;
    logic [31:0] expPc;
    string       expCause;
    logic        expHalted;
    logic        expExc;
    int          delivered = 0;
    int          valueErrors = 0;
    int          protocolErrors = 0;
    int          quietCycles = 0;

    // Last cycle as seen at the falling edge
    logic        prevHeld = 1'b0;
    logic [31:0] prevInstr;
    logic [31:0] prevPc;
    logic        prevCyc = 1'b0;
    logic        prevAck = 1'b0;
    logic [31:0] prevAdr;

    instrWord_u  word;
    instrWord_u  dWord;
    logic [31:0] nextPc;
    logic [31:0] genRoll;
    logic [31:0] stimRoll;
    logic [31:0] addrRoll;
    logic        nextStall;
    logic        nextRedirect;
    logic        misalign;

    fetchTop #(
        .resetVector (resetVector)
    ) u_fetchTop (.*);

    wishboneRomModel #(
        .waitSeed (seedInit)
    ) u_rom (
        .clk      (clk),
        .reset    (reset),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbAdr    (wbAdr),
        .wbDatOut (wbDatIn),
        .wbAck    (wbAck)
    );

    initial forever #(clkPeriod / 2) clk = ~clk;

    task automatic showMismatch(input string testName, input logic [31:0] expected,
                                input logic [31:0] actual);
        valueErrors++;
        $display("** Error [%s] expected 0x%08h, actual 0x%08h at %0t",
                 testName, expected, actual, $time);
    endtask

    task automatic noteFailure(input string what);
        protocolErrors++;
        $display("Check failed at %0t: %s", $time, what);
    endtask

    // SYSCALL or BREAK under the SPECIAL opcode
    function automatic logic isTrapWord(input logic [31:0] w);
        instrWord_u view;
        view = w;
        return view.rType.opcode == opSpecial &&
               (view.rType.funct == functSyscall || view.rType.funct == functBreak);
    endfunction

    // ==============================
    // Program, reset and end of run
    // ==============================

    initial begin
        seed = seedInit;
        expPc = resetVector;
        expCause = "reset";
        expHalted = 1'b0;
        expExc = 1'b0;
        // Mostly ALU words, a few jumps inside the ROM, rare traps
        for (i = 0; i < 1024; i++) begin
            genRoll = $random(seed);
            word = $random(seed);
            if (genRoll[4:0] < 5'd3) begin
                word.jType.opcode = genRoll[0] ? opJ : opJal;
                word.jType.index = {16'd0, genRoll[14:5]};
            end else if (genRoll[4:0] == 5'd3) begin
                word.rType.opcode = opSpecial;
                word.rType.funct = genRoll[5] ? functSyscall : functBreak;
            end else begin
                word.rType.opcode = opSpecial;
                if (word.rType.funct == functSyscall || word.rType.funct == functBreak) begin
                    word.rType.funct = 6'd32;
                end
            end
            romImage[i[9:0]] = word;
            u_rom.mem[i[9:0]] = word;
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        wait (delivered >= numInstr);
        $display("Error counts: %0d value mismatches, %0d other failures",
                 valueErrors, protocolErrors);
        if (valueErrors == 0 && protocolErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(timeoutNs);
        $display("Watchdog expired with %0d of %0d instructions delivered", delivered, numInstr);
        $display("Simulation FAILED");
        $finish;
    end

    // ==============================
    // Stall and redirect stimulus
    // ==============================

    always @(posedge clk) begin
        if (!reset) begin
            stimRoll = $random(seed);
            addrRoll = $random(seed);
            nextStall = stimRoll[1:0] == 2'b00;
            // Redirect far more often once fetch has stopped
            if (expHalted || expExc) begin
                nextRedirect = !nextStall && stimRoll[4:3] == 2'b00;
            end else begin
                nextRedirect = !nextStall && stimRoll[9:5] == 5'd0;
            end
            misalign = addrRoll[14:12] == 3'd0;
            stall <= nextStall;
            redirect <= nextRedirect;
            redirectAddr <= {20'd0, addrRoll[11:2], misalign ? {addrRoll[0], 1'b1} : 2'b00};
        end
    end

    // ==============================
    // Checks and reference model
    // ==============================

    always @(negedge clk) begin
        if (reset) begin
            if (wbCyc || instrValid || exception || halted) begin
                noteFailure("control output high during reset");
            end
        end else begin
            if (wbCyc !== wbStb || wbWe !== 1'b0 || wbSel !== 4'hf) begin
                noteFailure("Wishbone cyc, stb, we or sel out of rule");
            end
            if (wbCyc && prevCyc && !prevAck && wbAdr !== prevAdr) begin
                noteFailure("Wishbone address changed before ack");
            end
            // A stalled instruction stays put
            if (prevHeld && !instrValid) begin
                noteFailure("stalled instruction vanished");
            end
            if (prevHeld && instrPc !== prevPc) begin
                showMismatch("stall", prevPc, instrPc);
            end
            if (prevHeld && instr !== prevInstr) begin
                showMismatch("stall", prevInstr, instr);
            end
            if (exception !== expExc) begin
                showMismatch("redirect", 32'(expExc), 32'(exception));
            end
            if (expHalted && !halted) begin
                showMismatch("trap", 32'd1, 32'(halted));
            end
            // A trap word held by a stall may already show halted
            if (!expHalted && halted !== 1'b0 && !(instrValid && isTrapWord(instr))) begin
                showMismatch("trap", 32'd0, 32'(halted));
            end
            if ((expHalted || expExc) && instrValid) begin
                noteFailure("instruction delivered while fetch is stopped");
            end
            // A read issued in the redirect cycle itself may still open
            if ((expHalted || expExc) && quietCycles > 0 && wbCyc && !prevCyc) begin
                noteFailure("bus read started while fetch is stopped");
            end
            if (redirect) begin
                expPc = redirectAddr;
                expCause = "redirect";
                expExc = redirectAddr[1:0] != 2'b00;
                expHalted = 1'b0;
            end else if (instrValid && !stall) begin
                dWord = romImage[expPc[11:2]];
                if (instrPc !== expPc) begin
                    showMismatch(expCause, expPc, instrPc);
                end
                if (instr !== dWord) begin
                    showMismatch("sequential", dWord, instr);
                end
                nextPc = expPc + 32'd4;
                if (dWord.jType.opcode == opJ || dWord.jType.opcode == opJal) begin
                    expPc = {nextPc[31:28], dWord.jType.index, 2'b00};
                    expCause = "jump";
                end else if (isTrapWord(dWord)) begin
                    expHalted = 1'b1;
                    expCause = "trap";
                end else begin
                    expPc = nextPc;
                    expCause = "sequential";
                end
                delivered++;
            end
            prevHeld = instrValid && stall && !redirect;
            prevPc = instrPc;
            prevInstr = instr;
            quietCycles = redirect ? 0 : quietCycles + 1;
        end
        prevCyc = wbCyc;
        prevAck = wbAck;
        prevAdr = wbAdr;
    end

endmodule

//--- all.f
verilog/fetchPkg.sv
verilog/instructionFetch.sv
verilog/fetchBusMaster.sv
verilog/instructionPredecode.sv
verilog/fetchTop.sv
verif/wishboneRomModel.sv
verif/fetchTb.sv

//--- runSim.sh
#!/bin/sh
# Build the fetch testbench with Verilator, run it and look for the verdict in the log
rm -f sim.log \
    && verilator --binary --timing --timescale 1ns/100ps --top-module fetchTb \
        -f all.f -o fetchSim \
    && ./obj_dir/fetchSim | tee sim.log \
    && grep -q "^Simulation PASSED$" sim.log \
    && echo "fetchTb run succeeded" \
    || { echo "fetchTb run failed"; exit 1; }
